// File: spmm_pkg.sv
// Shared sizes, data types and decoder states of the sparse-times-dense WH multiplier
package spmm_pkg;

  // ======================================================================
  // Matrix sizes
  // ======================================================================
  // H columns and W rows
  localparam int NUM_FEATURE_IN  = 16;
  // W columns with one PE lane each
  localparam int NUM_FEATURE_OUT = 4;
  // Largest subgraph handled by the later stages
  localparam int MAX_NODES       = 168;

  // ======================================================================
  // Widths
  // ======================================================================
  localparam int DATA_WIDTH      = 8;
  // 16 products of 16 bits each fit without overflow
  localparam int ACC_WIDTH       = 20;
  localparam int PROD_WIDTH      = 2 * DATA_WIDTH;
  localparam int WH_ADDR_WIDTH   = 8;

  localparam int COL_IDX_WIDTH   = $clog2(NUM_FEATURE_IN);
  // Row length runs from 0 to NUM_FEATURE_IN inclusive
  localparam int ROW_LEN_WIDTH   = $clog2(NUM_FEATURE_IN + 1);
  localparam int NUM_NODE_WIDTH  = $clog2(MAX_NODES + 1);
  localparam int LANE_IDX_WIDTH  = $clog2(NUM_FEATURE_OUT);

  // ======================================================================
  // Data types
  // ======================================================================
  // H value or weight
  typedef logic signed [DATA_WIDTH-1:0]     data_t;
  typedef logic signed [PROD_WIDTH-1:0]     prod_t;
  typedef logic signed [ACC_WIDTH-1:0]      acc_t;

  typedef logic [COL_IDX_WIDTH-1:0]         col_idx_t;
  typedef logic [ROW_LEN_WIDTH-1:0]         row_len_t;
  typedef logic [NUM_NODE_WIDTH-1:0]        num_node_t;
  typedef logic [LANE_IDX_WIDTH-1:0]        lane_idx_t;
  typedef logic [WH_ADDR_WIDTH-1:0]         wh_addr_t;

  // One signed sum per output lane with lane 0 in the low bits
  typedef acc_t [NUM_FEATURE_OUT-1:0]       lane_vec_t;

  // One row of W indexed by lane
  typedef data_t [NUM_FEATURE_OUT-1:0]      wgt_row_t;

  // ======================================================================
  // Decoder FSM
  // ======================================================================
  typedef enum logic {
    ROW_IDLE,   // waiting for a header
    ROW_ACTIVE  // sending the beats of the current row
  } row_state_e;

endpackage

// File: spmm_ifs.sv
// Valid/ready links between the decoder, the PE array and the WH writer
`timescale 1ns/1ps

// ======================================================================
// Entry beats, decoder to PE array
// ======================================================================
interface entry_if import spmm_pkg::*; ();
  logic      valid;
  logic      ready;
  col_idx_t  col_idx;
  data_t     val;
  // Row boundary marks
  logic      first;
  logic      last;
  // Zero-length row sent as a single beat
  logic      empty;
  num_node_t num_node;
  logic      src_flag;

  modport dec (
    output valid, col_idx, val, first, last, empty, num_node, src_flag,
    input  ready
  );

  modport pe (
    input  valid, col_idx, val, first, last, empty, num_node, src_flag,
    output ready
  );
endinterface

// ======================================================================
// Finished row results, PE array to WH writer
// ======================================================================
interface result_if import spmm_pkg::*; ();
  logic      valid;
  logic      ready;
  lane_vec_t lanes;
  num_node_t num_node;
  logic      src_flag;

  modport pe (
    output valid, lanes, num_node, src_flag,
    input  ready
  );

  modport wr (
    input  valid, lanes, num_node, src_flag,
    output ready
  );
endinterface

// File: spmm_row_decoder.sv
// Row decoder that pairs nonzero entries with their header and marks row boundaries
`timescale 1ns/1ps

module spmm_row_decoder import spmm_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // Header stream
  input  logic      hdr_valid_i,
  output logic      hdr_ready_o,
  input  row_len_t  hdr_row_len_i,
  input  num_node_t hdr_num_node_i,
  input  logic      hdr_src_flag_i,

  // Nonzero stream
  input  logic      nz_valid_i,
  output logic      nz_ready_o,
  input  col_idx_t  nz_col_idx_i,
  input  data_t     nz_val_i,

  entry_if.dec      ent
);

  row_state_e state_q;
  row_len_t   beat_cnt_q;

  // Header of the row in flight
  row_len_t   row_len_q;
  num_node_t  num_node_q;
  logic       src_flag_q;

  logic       hdr_xfer;
  logic       ent_xfer;
  logic       empty_row;
  logic       last_beat;

  assign hdr_ready_o = (state_q == ROW_IDLE);
  assign hdr_xfer    = hdr_valid_i && hdr_ready_o;
  assign ent_xfer    = ent.valid && ent.ready;
  assign empty_row   = (row_len_q == '0);
  assign last_beat   = (row_len_t'(beat_cnt_q + 1'b1) == row_len_q);

  // Nonzero beats pass straight through and an empty row never takes one
  assign nz_ready_o = (state_q == ROW_ACTIVE) && !empty_row && ent.ready;

  // ======================================================================
  // Entry beat
  // ======================================================================
  always_comb begin
    ent.valid    = 1'b0;
    ent.col_idx  = '0;
    ent.val      = '0;
    ent.first    = 1'b0;
    ent.last     = 1'b0;
    ent.empty    = 1'b0;
    ent.num_node = num_node_q;
    ent.src_flag = src_flag_q;
    if (state_q == ROW_ACTIVE) begin
      if (empty_row) begin
        ent.valid = 1'b1;
        ent.first = 1'b1;
        ent.last  = 1'b1;
        ent.empty = 1'b1;
      end else begin
        ent.valid   = nz_valid_i;
        ent.col_idx = nz_col_idx_i;
        ent.val     = nz_val_i;
        ent.first   = (beat_cnt_q == '0);
        ent.last    = last_beat;
      end
    end
  end

  // ======================================================================
  // Row FSM and beat counter
  // ======================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ROW_IDLE;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        ROW_IDLE: begin
          if (hdr_xfer) begin
            state_q    <= ROW_ACTIVE;
            beat_cnt_q <= '0;
          end
        end
        ROW_ACTIVE: begin
          if (ent_xfer) begin
            if (ent.last) begin
              state_q <= ROW_IDLE;
            end else begin
              beat_cnt_q <= beat_cnt_q + 1'b1;
            end
          end
        end
        default: state_q <= ROW_IDLE;
      endcase
    end
  end

  // Header capture
  always_ff @(posedge clk) begin
    if (hdr_xfer) begin
      row_len_q  <= hdr_row_len_i;
      num_node_q <= hdr_num_node_i;
      src_flag_q <= hdr_src_flag_i;
    end
  end

endmodule

// File: spmm_pe_array.sv
// PE array holding the weight store and one multiply-accumulate lane per output feature
`timescale 1ns/1ps

module spmm_pe_array import spmm_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // Weight write port for use only while no row is in flight
  input  logic      wgt_we_i,
  input  col_idx_t  wgt_row_i,
  input  lane_idx_t wgt_col_i,
  input  data_t     wgt_data_i,

  entry_if.pe       ent,
  result_if.pe      res
);

  // ======================================================================
  // Weight store
  // ======================================================================
  wgt_row_t  wgt_q [NUM_FEATURE_IN];
  wgt_row_t  wgt_row;

  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      wgt_q[wgt_row_i][wgt_col_i] <= wgt_data_i;
    end
  end

  // Row of W selected by the column index of the beat
  assign wgt_row = wgt_q[ent.col_idx];

  // ======================================================================
  // Handshake
  // ======================================================================
  logic      ent_xfer;
  logic      last_xfer;
  logic      res_drain;
  logic      res_valid_q;

  // Only a last beat needs a free result slot
  assign ent.ready = !(ent.last && res_valid_q && !res.ready);
  assign ent_xfer  = ent.valid && ent.ready;
  assign last_xfer = ent_xfer && ent.last;
  assign res_drain = res_valid_q && res.ready;

  // ======================================================================
  // Lanes
  // ======================================================================
  lane_vec_t acc_q;
  lane_vec_t acc_nxt;

  for (genvar g = 0; g < NUM_FEATURE_OUT; g++) begin : g_lane
    prod_t prod;

    always_comb begin
      prod = wgt_row[g] * ent.val;
      if (ent.empty) begin
        prod = '0;
      end
    end

    // First beat restarts the sum
    assign acc_nxt[g] = ent.first ? acc_t'(prod) : acc_t'(acc_q[g] + acc_t'(prod));
  end

  always_ff @(posedge clk) begin
    if (ent_xfer) begin
      acc_q <= acc_nxt;
    end
  end

  // ======================================================================
  // Result register
  // ======================================================================
  lane_vec_t res_lanes_q;
  num_node_t res_num_node_q;
  logic      res_src_flag_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid_q <= 1'b0;
    end else if (last_xfer) begin
      res_valid_q <= 1'b1;
    end else if (res_drain) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (last_xfer) begin
      res_lanes_q    <= acc_nxt;
      res_num_node_q <= ent.num_node;
      res_src_flag_q <= ent.src_flag;
    end
  end

  assign res.valid    = res_valid_q;
  assign res.lanes    = res_lanes_q;
  assign res.num_node = res_num_node_q;
  assign res.src_flag = res_src_flag_q;

endmodule

// File: spmm_wh_writer.sv
// WH writer that buffers finished records and numbers them with the WH address
`timescale 1ns/1ps

module spmm_wh_writer import spmm_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  result_if.wr      res,

  output logic      wh_valid_o,
  input  logic      wh_ready_i,
  output lane_vec_t wh_lanes_o,
  output num_node_t wh_num_node_o,
  output logic      wh_src_flag_o,
  output wh_addr_t  wh_addr_o
);

  logic      wh_valid_q;
  wh_addr_t  wh_addr_q;
  lane_vec_t wh_lanes_q;
  num_node_t wh_num_node_q;
  logic      wh_src_flag_q;

  logic      res_xfer;
  logic      out_xfer;

  // Slot frees up in the same cycle the current record leaves
  assign res.ready = !wh_valid_q || wh_ready_i;
  assign res_xfer  = res.valid && res.ready;
  assign out_xfer  = wh_valid_q && wh_ready_i;

  // ======================================================================
  // Output record and address counter
  // ======================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_valid_q <= 1'b0;
      wh_addr_q  <= '0;
    end else begin
      if (res_xfer) begin
        wh_valid_q <= 1'b1;
      end else if (out_xfer) begin
        wh_valid_q <= 1'b0;
      end
      // Wraps at 256
      if (out_xfer) begin
        wh_addr_q <= wh_addr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (res_xfer) begin
      wh_lanes_q    <= res.lanes;
      wh_num_node_q <= res.num_node;
      wh_src_flag_q <= res.src_flag;
    end
  end

  assign wh_valid_o    = wh_valid_q;
  assign wh_lanes_o    = wh_lanes_q;
  assign wh_num_node_o = wh_num_node_q;
  assign wh_src_flag_o = wh_src_flag_q;
  assign wh_addr_o     = wh_addr_q;

endmodule

// File: spmm_top.sv
// Streaming sparse-times-dense multiplier computing one WH record per H row
`timescale 1ns/1ps

module spmm_top import spmm_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  // Header stream
  input  logic      hdr_valid_i,
  output logic      hdr_ready_o,
  input  row_len_t  hdr_row_len_i,
  input  num_node_t hdr_num_node_i,
  input  logic      hdr_src_flag_i,

  // Nonzero stream
  input  logic      nz_valid_i,
  output logic      nz_ready_o,
  input  col_idx_t  nz_col_idx_i,
  input  data_t     nz_val_i,

  // Weight write port
  input  logic      wgt_we_i,
  input  col_idx_t  wgt_row_i,
  input  lane_idx_t wgt_col_i,
  input  data_t     wgt_data_i,

  // WH records
  output logic      wh_valid_o,
  input  logic      wh_ready_i,
  output lane_vec_t wh_lanes_o,
  output num_node_t wh_num_node_o,
  output logic      wh_src_flag_o,
  output wh_addr_t  wh_addr_o
);

  entry_if  ent_if ();
  result_if res_if ();

  // ======================================================================
  // Decode, execute and write stages
  // ======================================================================
  spmm_row_decoder u_decoder (
    .clk            (clk),
    .rst_n          (rst_n),
    .hdr_valid_i    (hdr_valid_i),
    .hdr_ready_o    (hdr_ready_o),
    .hdr_row_len_i  (hdr_row_len_i),
    .hdr_num_node_i (hdr_num_node_i),
    .hdr_src_flag_i (hdr_src_flag_i),
    .nz_valid_i     (nz_valid_i),
    .nz_ready_o     (nz_ready_o),
    .nz_col_idx_i   (nz_col_idx_i),
    .nz_val_i       (nz_val_i),
    .ent            (ent_if.dec)
  );

  spmm_pe_array u_pe_array (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_we_i   (wgt_we_i),
    .wgt_row_i  (wgt_row_i),
    .wgt_col_i  (wgt_col_i),
    .wgt_data_i (wgt_data_i),
    .ent        (ent_if.pe),
    .res        (res_if.pe)
  );

  spmm_wh_writer u_wh_writer (
    .clk           (clk),
    .rst_n         (rst_n),
    .res           (res_if.wr),
    .wh_valid_o    (wh_valid_o),
    .wh_ready_i    (wh_ready_i),
    .wh_lanes_o    (wh_lanes_o),
    .wh_num_node_o (wh_num_node_o),
    .wh_src_flag_o (wh_src_flag_o),
    .wh_addr_o     (wh_addr_o)
  );

endmodule

// File: spmm_checker.sv
// Protocol assertions on the header, nonzero and WH streams of the multiplier
`timescale 1ns/1ps

module spmm_checker import spmm_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      hdr_ready_o,
  input logic      nz_ready_o,
  input logic      wh_valid_o,
  input logic      wh_ready_i,
  input lane_vec_t wh_lanes_o,
  input num_node_t wh_num_node_o,
  input logic      wh_src_flag_o,
  input wh_addr_t  wh_addr_o
);

  // Stalled record keeps valid and payload
  a_out_stable : assert property (@(posedge clk) disable iff (!rst_n)
    wh_valid_o && !wh_ready_i |=> wh_valid_o && $stable(wh_lanes_o)
      && $stable(wh_num_node_o) && $stable(wh_src_flag_o) && $stable(wh_addr_o))
    else $error("WH record changed while stalled");

  // Header and nonzero streams never open together
  a_hdr_nz_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(nz_ready_o && hdr_ready_o))
    else $error("nz_ready_o high while hdr_ready_o high");

  a_addr_step : assert property (@(posedge clk) disable iff (!rst_n)
    wh_valid_o && wh_ready_i |=> wh_addr_o == wh_addr_t'($past(wh_addr_o) + 1'b1))
    else $error("WH address did not step by one");

  a_reset_quiet : assert property (@(posedge clk) !rst_n |-> !wh_valid_o)
    else $error("wh_valid_o high during reset");

endmodule

bind spmm_top spmm_checker u_checker (
  .clk           (clk),
  .rst_n         (rst_n),
  .hdr_ready_o   (hdr_ready_o),
  .nz_ready_o    (nz_ready_o),
  .wh_valid_o    (wh_valid_o),
  .wh_ready_i    (wh_ready_i),
  .wh_lanes_o    (wh_lanes_o),
  .wh_num_node_o (wh_num_node_o),
  .wh_src_flag_o (wh_src_flag_o),
  .wh_addr_o     (wh_addr_o)
);

// File: tb_spmm.sv
// Testbench for the WH multiplier with random rows, weight reloads and output stalls
`timescale 1ns/1ps

module tb_spmm import spmm_pkg::*; ();

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic hdr_valid_i = 1'b0;
  logic hdr_ready_o;
  logic hdr_src_flag_i = 1'b0;
  row_len_t hdr_row_len_i = '0;
  num_node_t hdr_num_node_i = '0;
  logic nz_valid_i = 1'b0;
  logic nz_ready_o;
  col_idx_t nz_col_idx_i = '0;
  data_t nz_val_i = '0;
  logic wgt_we_i = 1'b0;
  col_idx_t wgt_row_i = '0;
  lane_idx_t wgt_col_i = '0;
  data_t wgt_data_i = '0;
  logic wh_valid_o;
  logic wh_ready_i = 1'b1;
  logic wh_src_flag_o;
  lane_vec_t wh_lanes_o;
  num_node_t wh_num_node_o;
  wh_addr_t wh_addr_o;

  data_t w_ref [NUM_FEATURE_IN][NUM_FEATURE_OUT];
  col_idx_t row_cols [NUM_FEATURE_IN];
  data_t row_vals [NUM_FEATURE_IN];
  lane_vec_t exp_lanes_q [$];
  num_node_t exp_node_q [$];
  bit exp_flag_q [$];
  int beats_sent = 0;
  int out_count = 0;
  logic [31:0] rng_state = 32'd39494;
  logic [31:0] rdy_state = 32'd39494;
  bit rand_ready = 1'b0;

  spmm_top u_dut (.*);

  always #20 clk = ~clk;

  // ==================================================================
  // Helpers
  // ==================================================================
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Expected lanes from the testbench copy of W
  function automatic lane_vec_t ref_lanes(int len, col_idx_t cols [NUM_FEATURE_IN],
                                          data_t vals [NUM_FEATURE_IN]);
    lane_vec_t res;
    int sum;
    for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
      sum = 0;
      for (int i = 0; i < len; i++) begin
        sum += int'(vals[i]) * int'(w_ref[cols[i]][l]);
      end
      res[l] = acc_t'(sum);
    end
    return res;
  endfunction

  task automatic stop_on_error();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_lanes(string name, lane_vec_t exp, lane_vec_t act);
    if (exp !== act) begin
      $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_num_node(string name, num_node_t exp, num_node_t act);
    if (exp !== act) begin
      $display("FAILED time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_flag(string name, bit exp, logic act);
    if (act !== exp) begin
      $display("FAILED time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_addr(string name, wh_addr_t exp, wh_addr_t act);
    if (exp !== act) begin
      $display("FAILED time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  // Pattern load puts the extremes on lane 0
  task automatic load_weights(bit random_fill);
    data_t d;
    for (int r = 0; r < NUM_FEATURE_IN; r++) begin
      for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
        if (random_fill) d = data_t'(next_rand());
        else if (l == 0) d = (r % 2 == 0) ? data_t'(-128) : data_t'(127);
        else d = data_t'(r * 37 + l * 101 + 3);
        w_ref[r][l] = d;
        wgt_we_i = 1'b1;
        wgt_row_i = col_idx_t'(r);
        wgt_col_i = lane_idx_t'(l);
        wgt_data_i = d;
        @(posedge clk);
        #2;
        beats_sent++;
      end
    end
    wgt_we_i = 1'b0;
  endtask

  // Sends the header and then the entries held in row_cols and row_vals
  task automatic send_row(int len, num_node_t nn, bit flag);
    exp_lanes_q.push_back(ref_lanes(len, row_cols, row_vals));
    exp_node_q.push_back(nn);
    exp_flag_q.push_back(flag);
    hdr_valid_i = 1'b1;
    hdr_row_len_i = row_len_t'(len);
    hdr_num_node_i = nn;
    hdr_src_flag_i = flag;
    @(negedge clk);
    while (!hdr_ready_o) @(negedge clk);
    @(posedge clk);
    #2;
    hdr_valid_i = 1'b0;
    beats_sent++;
    for (int i = 0; i < len; i++) begin
      nz_valid_i = 1'b1;
      nz_col_idx_i = row_cols[i];
      nz_val_i = row_vals[i];
      @(negedge clk);
      while (!nz_ready_o) @(negedge clk);
      @(posedge clk);
      #2;
      beats_sent++;
    end
    nz_valid_i = 1'b0;
  endtask

  task automatic run_random_rows(int count);
    int len;
    num_node_t nn;
    bit flag;
    for (int r = 0; r < count; r++) begin
      len = int'(next_rand() % 17);
      nn = num_node_t'(1 + next_rand() % MAX_NODES);
      flag = (next_rand() % 2) == 1;
      for (int i = 0; i < len; i++) begin
        row_cols[i] = col_idx_t'(next_rand());
        row_vals[i] = data_t'(next_rand());
      end
      send_row(len, nn, flag);
    end
  endtask

  task automatic wait_drained();
    while (exp_lanes_q.size() != 0) begin
      @(posedge clk);
      #2;
    end
  endtask

  // ==================================================================
  // Output stall pattern, monitor and watchdog
  // ==================================================================
  always @(posedge clk) begin
    #2;
    rdy_state = xorshift32(rdy_state);
    wh_ready_i = rand_ready ? rdy_state[3] : 1'b1;
  end

  always @(negedge clk) begin
    if (rst_n && wh_valid_o && wh_ready_i) begin
      if (exp_lanes_q.size() == 0) begin
        $display("Error at time %0t: a WH record came out with none expected", $time);
        stop_on_error();
      end else begin
        check_lanes("wh_lanes_o", exp_lanes_q.pop_front(), wh_lanes_o);
        check_num_node("wh_num_node_o", exp_node_q.pop_front(), wh_num_node_o);
        check_flag("wh_src_flag_o", exp_flag_q.pop_front(), wh_src_flag_o);
        check_addr("wh_addr_o", wh_addr_t'(out_count), wh_addr_o);
        out_count++;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > beats_sent * 4 + 200) begin
        $display("Watchdog expired: outputs stalled after %0d cycles, %0d beats sent",
                 cycles, beats_sent);
        stop_on_error();
      end
    end
  end

  // ==================================================================
  // Stimulus
  // ==================================================================
  initial begin
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // Idle after reset
    repeat (5) begin
      @(negedge clk);
      check_flag("wh_valid_o", 1'b0, wh_valid_o);
      check_flag("hdr_ready_o", 1'b1, hdr_ready_o);
      check_flag("nz_ready_o", 1'b0, nz_ready_o);
    end
    @(posedge clk);
    #2;
    load_weights(1'b0);
    // Full row with extreme values
    for (int i = 0; i < NUM_FEATURE_IN; i++) begin
      row_cols[i] = col_idx_t'(i);
      row_vals[i] = (i == 0) ? data_t'(-128) : (i == 15) ? data_t'(127) : data_t'(i * 23 - 90);
    end
    send_row(16, num_node_t'(168), 1'b1);
    send_row(0, num_node_t'(77), 1'b0);
    row_cols[0] = col_idx_t'(5);
    row_cols[1] = col_idx_t'(5);
    row_cols[2] = col_idx_t'(9);
    row_vals[0] = data_t'(10);
    row_vals[1] = data_t'(-20);
    row_vals[2] = data_t'(-128);
    send_row(3, num_node_t'(12), 1'b1);
    run_random_rows(60);
    rand_ready = 1'b1;
    run_random_rows(60);
    wait_drained();
    load_weights(1'b1);
    run_random_rows(30);
    wait_drained();
    // Room for a duplicate record to show up
    repeat (20) @(posedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: src.f
spmm_pkg.sv
spmm_ifs.sv
spmm_row_decoder.sv
spmm_pe_array.sv
spmm_wh_writer.sv
spmm_top.sv
spmm_checker.sv
tb_spmm.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_spmm -f src.f -o sim_spmm
./obj_dir/sim_spmm | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
